/* compile.f */
+incdir+design
design/lsu_pkg.sv
design/lsu_req_ingress.sv
design/lsu_data_ram.sv
design/lsu_load_align.sv
design/lsu_top.sv
test/lsu_sva.sv
test/lsu_tb.sv

/* run_sim.sh */
#!/bin/sh
# builds the lsu testbench with verilator, runs it and fails unless the pass line is printed.
cd "$(dirname "$0")" &&
  verilator --binary --timing --assert --top-module lsu_tb -f compile.f -o lsu_sim &&
  ./obj_dir/lsu_sim | tee /dev/stderr | grep -q "^NO ERRORS$" &&
  echo "simulation passed" || { echo "simulation failed"; exit 1; }

/* test/lsu_tb.sv */
// lsu testbench: drives credit-controlled requests into lsu_top and checks every response.
`timescale 1ns/1ps
`include "lsu_settings.svh"

module lsu_tb;
  import lsu_pkg::*;

  localparam int WAIT_LIMIT  = 500;
  localparam int DRAIN_LIMIT = 2000;
  localparam int MEM_BYTES   = `LSU_MEM_WORDS * 8;

  logic        i_clk;
  logic        i_rst;
  logic        i_req_valid;
  logic        i_req_write;
  logic [63:0] i_req_addr;
  logic [63:0] i_req_wdata;
  lsu_memop_u  i_req_op;
  logic        i_rsp_credit;
  logic        o_req_credit;
  logic        o_rsp_valid;
  logic [63:0] o_rsp_data;
  logic        o_rsp_err;
  logic        o_rsp_write;

  logic [7:0]  ref_mem [MEM_BYTES] = '{default: 8'h00};
  logic [63:0] exp_data [$];
  logic        exp_err [$];
  logic        exp_write [$];
  string       exp_name [$];
  string       test_name;
  int          req_credits;
  int          requests_sent;
  int          credit_pulses;
  int          hold_cycles;
  logic        bursts_on;

  lsu_top i_lsu_top (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_req_valid  (i_req_valid),
    .i_req_write  (i_req_write),
    .i_req_addr   (i_req_addr),
    .i_req_wdata  (i_req_wdata),
    .i_req_op     (i_req_op),
    .o_req_credit (o_req_credit),
    .o_rsp_valid  (o_rsp_valid),
    .o_rsp_data   (o_rsp_data),
    .o_rsp_err    (o_rsp_err),
    .o_rsp_write  (o_rsp_write),
    .i_rsp_credit (i_rsp_credit)
  );

  initial begin
    i_clk = 1'b0;
    forever #50 i_clk = ~i_clk;
  end

  task automatic report_mismatch(input string name, input string field,
                                 input logic [63:0] exp, input logic [63:0] act);
    $display("[FAIL] %s %s expected %h actual %h", name, field, exp, act);
    $display("ERRORS FOUND");
    $fatal(1, "stopping at the first mismatch");
  endtask

  task automatic report_problem(input string what);
    $display("%s", what);
    $display("ERRORS FOUND");
    $fatal(1, "stopping at the first error");
  endtask

  function automatic logic misaligned(input logic [2:0] off, input logic [2:0] op);
    return (off & ~(3'b111 << op[2:1])) != 3'b000;
  endfunction

  // aliases above bit 10 must land on the same word.
  function automatic logic [63:0] make_addr(input logic [7:0] idx, input logic [2:0] off);
    logic [63:0] hi;
    hi = {$urandom, $urandom};
    return {hi[63:11], idx, off};
  endfunction

  // little-endian read of the reference bytes, then sign or zero extension.
  function automatic logic [63:0] model_load(input logic [63:0] addr, input logic [2:0] op);
    logic [63:0] val;
    logic [10:0] ba;
    val = 64'h0;
    for (int i = 0; i < (1 << op[2:1]); i++) begin
      ba  = addr[10:0] + 11'(i);
      val = val | (64'(ref_mem[ba]) << (8 * i));
    end
    case (op[2:1])
      2'd0:    val = op[0] ? {56'h0, val[7:0]} : {{56{val[7]}}, val[7:0]};
      2'd1:    val = op[0] ? {48'h0, val[15:0]} : {{48{val[15]}}, val[15:0]};
      2'd2:    val = op[0] ? {32'h0, val[31:0]} : {{32{val[31]}}, val[31:0]};
      default: val = val;
    endcase
    return val;
  endfunction

  task automatic check_response();
    logic [63:0] exp_d;
    logic        exp_e;
    logic        exp_w;
    string       name;
    if (exp_data.size() == 0) report_problem("a response arrived with no request outstanding");
    exp_d = exp_data.pop_front();
    exp_e = exp_err.pop_front();
    exp_w = exp_write.pop_front();
    name  = exp_name.pop_front();
    assert (o_rsp_data == exp_d) else report_mismatch(name, "rsp_data", exp_d, o_rsp_data);
    assert (o_rsp_err == exp_e) else report_mismatch(name, "rsp_err", 64'(exp_e), 64'(o_rsp_err));
    assert (o_rsp_write == exp_w)
      else report_mismatch(name, "rsp_write", 64'(exp_w), 64'(o_rsp_write));
  endtask

  // one cycle: observe the registered outputs, then drive the next inputs.
  task automatic tick();
    @(negedge i_clk);
    if (o_req_credit) begin
      req_credits++;
      credit_pulses++;
    end
    if (o_rsp_valid) check_response();
    i_req_valid = 1'b0;
    if (hold_cycles > 0) begin
      i_rsp_credit = 1'b0;
      hold_cycles--;
    end else begin
      i_rsp_credit = ($urandom % 3) != 0;
      if (bursts_on && ($urandom % 40) == 0) hold_cycles = 20 + int'($urandom % 40);
    end
  endtask

  task automatic send_request(input logic write, input logic [63:0] addr,
                              input logic [63:0] wdata, input logic [2:0] op);
    int          waited;
    logic        nop;
    logic        bad;
    logic [10:0] ba;
    waited = 0;
    tick();
    while (req_credits == 0) begin
      waited++;
      if (waited > WAIT_LIMIT) report_problem("timed out waiting for a request credit");
      tick();
    end
    i_req_valid  = 1'b1;
    i_req_write  = write;
    i_req_addr   = addr;
    i_req_wdata  = wdata;
    i_req_op.raw = op;
    req_credits--;
    requests_sent++;
    nop = (op == 3'b111);
    bad = !nop && misaligned(addr[2:0], op);
    exp_data.push_back((write || nop || bad) ? 64'h0 : model_load(addr, op));
    exp_err.push_back(bad);
    exp_write.push_back(write);
    exp_name.push_back(test_name);
    if (write && !nop && !bad) begin
      for (int i = 0; i < (1 << op[2:1]); i++) begin
        ba          = addr[10:0] + 11'(i);
        ref_mem[ba] = 8'(wdata >> (8 * i));
      end
    end
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    while (exp_data.size() != 0) begin
      waited++;
      if (waited > DRAIN_LIMIT) report_problem("timed out waiting for outstanding responses");
      tick();
    end
  endtask

  initial begin
    logic [7:0]  idx;
    logic [63:0] data;
    logic [2:0]  op3;
    void'($urandom(93160));
    i_rst         = 1'b0;
    i_req_valid   = 1'b0;
    i_req_write   = 1'b0;
    i_req_addr    = 64'h0;
    i_req_wdata   = 64'h0;
    i_req_op.raw  = 3'b000;
    i_rsp_credit  = 1'b0;
    bursts_on     = 1'b0;
    requests_sent = 0;
    credit_pulses = 0;
    hold_cycles   = 0;
    req_credits   = `LSU_REQ_DEPTH;
    repeat (4) @(posedge i_clk);
    @(negedge i_clk);
    i_rst = 1'b1;

    // a full burst on the credits held after reset, with response credits withheld.
    test_name   = "reset_burst";
    hold_cycles = 12;
    for (int k = 0; k < `LSU_REQ_DEPTH; k++) begin
      send_request(1'b1, make_addr(8'(k), 3'd0), {$urandom, $urandom}, 3'b110);
    end
    // reading the words back shows that every store of the burst was performed.
    for (int k = 0; k < `LSU_REQ_DEPTH; k++) begin
      send_request(1'b0, make_addr(8'(k), 3'd0), 64'h0, 3'b110);
    end
    drain();

    test_name = "load_extend";
    for (int op = 0; op < 7; op++) begin
      for (int off = 0; off < 8; off += (1 << op[2:1])) begin
        for (int r = 0; r < 2; r++) begin
          idx  = 8'($urandom);
          data = {$urandom, $urandom};
          data = (r == 0) ? (data & ~64'h8080808080808080) : (data | 64'h8080808080808080);
          send_request(1'b1, make_addr(idx, off[2:0]), data, op[2:0]);
          send_request(1'b0, make_addr(idx, off[2:0]), 64'h0, op[2:0]);
        end
      end
    end
    drain();

    test_name = "partial_store";
    for (int r = 0; r < 8; r++) begin
      idx = 8'($urandom);
      send_request(1'b1, make_addr(idx, 3'd0), {$urandom, $urandom}, 3'b110);
      for (int k = 0; k < 3; k++) begin
        op3 = {2'($urandom % 3), 1'b0};
        send_request(1'b1, make_addr(idx, 3'($urandom) & (3'b111 << op3[2:1])),
                     {$urandom, $urandom}, op3);
      end
      send_request(1'b0, make_addr(idx, 3'd0), 64'h0, 3'b110);
    end
    drain();

    test_name = "misaligned";
    idx = 8'($urandom);
    send_request(1'b1, make_addr(idx, 3'd0), {$urandom, $urandom}, 3'b110);
    for (int op = 2; op < 7; op++) begin
      for (int off = 1; off < 8; off++) begin
        if (misaligned(off[2:0], op[2:0])) begin
          send_request(1'b1, make_addr(idx, off[2:0]), {$urandom, $urandom}, op[2:0]);
          send_request(1'b0, make_addr(idx, off[2:0]), 64'h0, op[2:0]);
        end
      end
    end
    send_request(1'b0, make_addr(idx, 3'd0), 64'h0, 3'b110);
    drain();

    test_name = "no_op";
    idx = 8'($urandom);
    send_request(1'b1, make_addr(idx, 3'd0), {$urandom, $urandom}, 3'b110);
    send_request(1'b1, make_addr(idx, 3'($urandom)), {$urandom, $urandom}, 3'b111);
    send_request(1'b0, make_addr(idx, 3'($urandom)), 64'h0, 3'b111);
    send_request(1'b0, make_addr(idx, 3'd0), 64'h0, 3'b110);
    drain();

    // random traffic over a few words while response credits stall in long bursts.
    test_name   = "backpressure";
    bursts_on   = 1'b1;
    hold_cycles = 60;
    for (int n = 0; n < 200; n++) begin
      send_request(($urandom % 2) != 0, make_addr(8'($urandom % 8), 3'($urandom)),
                   {$urandom, $urandom}, 3'($urandom));
    end
    drain();
    bursts_on = 1'b0;

    repeat (10) tick();
    assert (credit_pulses == requests_sent)
      else report_mismatch("credit_return", "req_credit_pulses", 64'(requests_sent),
                           64'(credit_pulses));
    $display("NO ERRORS");
    $finish;
  end

endmodule

/* test/lsu_sva.sv */
// lsu assertions: credit limits, reset state and response legality at the top level.
`timescale 1ns/1ps
`include "lsu_settings.svh"

module lsu_sva (
  input logic        i_clk,
  input logic        i_rst,
  input logic        i_req_valid,
  input logic        i_req_credit,
  input logic        i_rsp_credit,
  input logic        i_rsp_valid,
  input logic        i_rsp_err,
  input logic [63:0] i_rsp_data
);

  int outstanding;
  int granted;
  int sent;

  // shadow counts of request credits in use and response credits granted and spent.
  always_ff @(posedge i_clk) begin
    if (!i_rst) begin
      outstanding <= 0;
      granted     <= `LSU_RSP_CREDITS;
      sent        <= 0;
    end else begin
      outstanding <= outstanding + 32'(i_req_valid) - 32'(i_req_credit);
      granted     <= granted + 32'(i_rsp_credit);
      sent        <= sent + 32'(i_rsp_valid);
    end
  end

  rsp_needs_credit: assert property (@(posedge i_clk) disable iff (!i_rst)
    i_rsp_valid |-> (sent < granted))
    else $error("response sent without a response credit");

  req_within_depth: assert property (@(posedge i_clk) disable iff (!i_rst)
    outstanding <= `LSU_REQ_DEPTH)
    else $error("more requests outstanding than the request queue holds");

  quiet_in_reset: assert property (@(posedge i_clk)
    !i_rst |=> (!i_req_credit && !i_rsp_valid))
    else $error("credit or response pulse while reset is active");

  err_has_zero_data: assert property (@(posedge i_clk) disable iff (!i_rst)
    (i_rsp_valid && i_rsp_err) |-> (i_rsp_data == 64'h0))
    else $error("error response carries nonzero data");

endmodule

bind lsu_top lsu_sva u_lsu_sva (
  .i_clk        (i_clk),
  .i_rst        (i_rst),
  .i_req_valid  (i_req_valid),
  .i_req_credit (o_req_credit),
  .i_rsp_credit (i_rsp_credit),
  .i_rsp_valid  (o_rsp_valid),
  .i_rsp_err    (o_rsp_err),
  .i_rsp_data   (o_rsp_data)
);

/* design/lsu_top.sv */
// lsu top level: connects the request ingress, the data memory and the load aligner.
`timescale 1ns/1ps
`include "lsu_settings.svh"

module lsu_top (
  input  logic                i_clk,
  input  logic                i_rst,
  input  logic                i_req_valid,
  input  logic                i_req_write,
  input  logic [63:0]         i_req_addr,
  input  logic [63:0]         i_req_wdata,
  input  lsu_pkg::lsu_memop_u i_req_op,
  output logic                o_req_credit,
  output logic                o_rsp_valid,
  output logic [63:0]         o_rsp_data,
  output logic                o_rsp_err,
  output logic                o_rsp_write,
  input  logic                i_rsp_credit
);
  import lsu_pkg::*;

  logic                      mem_wr_en;
  logic                      mem_rd_en;
  logic [`LSU_MEM_IDX_W-1:0] mem_index;
  logic [7:0]                mem_wmask;
  logic [63:0]               mem_wdata;
  logic [63:0]               rd_word;
  logic                      iss_valid;
  logic                      iss_write;
  lsu_memop_u                iss_op;
  logic [2:0]                iss_offset;
  logic                      iss_err;
  logic                      iss_kill;
  logic                      iss_room;

  lsu_req_ingress u_req_ingress (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_req_valid  (i_req_valid),
    .i_req_write  (i_req_write),
    .i_req_addr   (i_req_addr),
    .i_req_wdata  (i_req_wdata),
    .i_req_op     (i_req_op),
    .i_iss_room   (iss_room),
    .o_req_credit (o_req_credit),
    .o_mem_wr_en  (mem_wr_en),
    .o_mem_rd_en  (mem_rd_en),
    .o_mem_index  (mem_index),
    .o_mem_wmask  (mem_wmask),
    .o_mem_wdata  (mem_wdata),
    .o_iss_valid  (iss_valid),
    .o_iss_write  (iss_write),
    .o_iss_op     (iss_op),
    .o_iss_offset (iss_offset),
    .o_iss_err    (iss_err),
    .o_iss_kill   (iss_kill)
  );

  lsu_data_ram u_data_ram (
    .i_clk     (i_clk),
    .i_wr_en   (mem_wr_en),
    .i_rd_en   (mem_rd_en),
    .i_index   (mem_index),
    .i_wmask   (mem_wmask),
    .i_wdata   (mem_wdata),
    .o_rd_word (rd_word)
  );

  lsu_load_align u_load_align (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_iss_valid  (iss_valid),
    .i_iss_write  (iss_write),
    .i_iss_op     (iss_op),
    .i_iss_offset (iss_offset),
    .i_iss_err    (iss_err),
    .i_iss_kill   (iss_kill),
    .i_rd_word    (rd_word),
    .i_rsp_credit (i_rsp_credit),
    .o_iss_room   (iss_room),
    .o_rsp_valid  (o_rsp_valid),
    .o_rsp_data   (o_rsp_data),
    .o_rsp_err    (o_rsp_err),
    .o_rsp_write  (o_rsp_write)
  );

endmodule

/* design/lsu_load_align.sv */
// lsu load aligner: extends read data, queues responses and sends them under response credits.
`timescale 1ns/1ps
`include "lsu_settings.svh"

module lsu_load_align (
  input  logic                i_clk,
  input  logic                i_rst,
  input  logic                i_iss_valid,
  input  logic                i_iss_write,
  input  lsu_pkg::lsu_memop_u i_iss_op,
  input  logic [2:0]          i_iss_offset,
  input  logic                i_iss_err,
  input  logic                i_iss_kill,
  input  logic [63:0]         i_rd_word,
  input  logic                i_rsp_credit,
  output logic                o_iss_room,
  output logic                o_rsp_valid,
  output logic [63:0]         o_rsp_data,
  output logic                o_rsp_err,
  output logic                o_rsp_write
);
  import lsu_pkg::*;

  localparam int PTR_W = $clog2(`LSU_RSP_QUEUE);
  localparam int CNT_W = $clog2(`LSU_RSP_QUEUE + 1);

  logic                     sb_valid;
  logic                     sb_write;
  lsu_memop_u               sb_op;
  logic [2:0]               sb_offset;
  logic                     sb_err;
  logic                     sb_kill;
  logic [63:0]              shifted;
  logic                     sign;
  logic [63:0]              extended;
  logic [63:0]              rsp_data;
  logic [63:0]              rq_data  [`LSU_RSP_QUEUE];
  logic                     rq_err   [`LSU_RSP_QUEUE];
  logic                     rq_write [`LSU_RSP_QUEUE];
  logic [PTR_W-1:0]         wr_ptr;
  logic [PTR_W-1:0]         rd_ptr;
  logic [CNT_W-1:0]         count;
  logic [`LSU_RSP_CNT_W-1:0] credits;
  logic                     pop;

  // the side-band waits one cycle here, as the memory does for the read word.
  always_ff @(posedge i_clk) begin
    if (!i_rst) begin
      sb_valid <= 1'b0;
    end else begin
      sb_valid <= i_iss_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_iss_valid) begin
      sb_write  <= i_iss_write;
      sb_op     <= i_iss_op;
      sb_offset <= i_iss_offset;
      sb_err    <= i_iss_err;
      sb_kill   <= i_iss_kill;
    end
  end

  always_comb begin
    shifted = i_rd_word >> {sb_offset, 3'b000};
    case (sb_op.f.size)
      LSU_SIZE_BYTE: begin
        sign     = shifted[7] & ~sb_op.f.is_unsigned;
        extended = {{56{sign}}, shifted[7:0]};
      end
      LSU_SIZE_HALF: begin
        sign     = shifted[15] & ~sb_op.f.is_unsigned;
        extended = {{48{sign}}, shifted[15:0]};
      end
      LSU_SIZE_WORD: begin
        sign     = shifted[31] & ~sb_op.f.is_unsigned;
        extended = {{32{sign}}, shifted[31:0]};
      end
      default: begin
        sign     = 1'b0;
        extended = shifted;
      end
    endcase
  end

  // stores, no-ops and errors return zero data.
  assign rsp_data = (sb_write || sb_kill) ? 64'h0 : extended;

  always_ff @(posedge i_clk) begin
    if (sb_valid) begin
      rq_data[wr_ptr]  <= rsp_data;
      rq_err[wr_ptr]   <= sb_err;
      rq_write[wr_ptr] <= sb_write;
    end
  end

  assign pop = (count != '0) && (credits != '0);

  // an access in flight already owns a queue slot.
  assign o_iss_room = (32'(count) + 32'(sb_valid)) < `LSU_RSP_QUEUE;

  always_ff @(posedge i_clk) begin
    if (!i_rst) begin
      wr_ptr      <= '0;
      rd_ptr      <= '0;
      count       <= '0;
      credits     <= `LSU_RSP_CNT_W'(`LSU_RSP_CREDITS);
      o_rsp_valid <= 1'b0;
    end else begin
      if (sb_valid) begin
        wr_ptr <= (wr_ptr == PTR_W'(`LSU_RSP_QUEUE - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(`LSU_RSP_QUEUE - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({sb_valid, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      case ({i_rsp_credit, pop})
        2'b10:   credits <= credits + 1'b1;
        2'b01:   credits <= credits - 1'b1;
        default: credits <= credits;
      endcase
      o_rsp_valid <= pop;
    end
  end

  // response payload is only meaningful while o_rsp_valid is high.
  always_ff @(posedge i_clk) begin
    if (pop) begin
      o_rsp_data  <= rq_data[rd_ptr];
      o_rsp_err   <= rq_err[rd_ptr];
      o_rsp_write <= rq_write[rd_ptr];
    end
  end

endmodule

/* design/lsu_data_ram.sv */
// lsu data memory: 64-bit word array with byte-masked writes and a registered read.
`timescale 1ns/1ps
`include "lsu_settings.svh"

module lsu_data_ram (
  input  logic                      i_clk,
  input  logic                      i_wr_en,
  input  logic                      i_rd_en,
  input  logic [`LSU_MEM_IDX_W-1:0] i_index,
  input  logic [7:0]                i_wmask,
  input  logic [63:0]               i_wdata,
  output logic [63:0]               o_rd_word
);

  // contents start at zero so that a load before any store is defined.
  logic [63:0] mem [`LSU_MEM_WORDS] = '{default: 64'h0};

  // each byte lane is written only when its mask bit is set.
  always_ff @(posedge i_clk) begin
    if (i_wr_en) begin
      for (int b = 0; b < 8; b++) begin
        if (i_wmask[b]) begin
          mem[i_index][8*b +: 8] <= i_wdata[8*b +: 8];
        end
      end
    end
  end

  // the word read at an edge is visible until the next read.
  // the ingress never reads and writes in the same cycle.
  always_ff @(posedge i_clk) begin
    if (i_rd_en) begin
      o_rd_word <= mem[i_index];
    end
  end

endmodule

/* design/lsu_req_ingress.sv */
// lsu request ingress: queues requests under credit control and issues aligned accesses.
`timescale 1ns/1ps
`include "lsu_settings.svh"

module lsu_req_ingress (
  input  logic                      i_clk,
  input  logic                      i_rst,
  input  logic                      i_req_valid,
  input  logic                      i_req_write,
  input  logic [63:0]               i_req_addr,
  input  logic [63:0]               i_req_wdata,
  input  lsu_pkg::lsu_memop_u       i_req_op,
  input  logic                      i_iss_room,
  output logic                      o_req_credit,
  output logic                      o_mem_wr_en,
  output logic                      o_mem_rd_en,
  output logic [`LSU_MEM_IDX_W-1:0] o_mem_index,
  output logic [7:0]                o_mem_wmask,
  output logic [63:0]               o_mem_wdata,
  output logic                      o_iss_valid,
  output logic                      o_iss_write,
  output lsu_pkg::lsu_memop_u       o_iss_op,
  output logic [2:0]                o_iss_offset,
  output logic                      o_iss_err,
  output logic                      o_iss_kill
);
  import lsu_pkg::*;

  localparam int PTR_W = $clog2(`LSU_REQ_DEPTH);
  localparam int CNT_W = $clog2(`LSU_REQ_DEPTH + 1);

  logic             q_write [`LSU_REQ_DEPTH];
  logic [63:0]      q_addr  [`LSU_REQ_DEPTH];
  logic [63:0]      q_wdata [`LSU_REQ_DEPTH];
  lsu_memop_u       q_op    [`LSU_REQ_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic [63:0]      head_addr;
  logic [2:0]       offset;
  logic             is_nop;
  logic             misaligned;
  logic [7:0]       base_mask;

  // the queue has no ready. the requester's credits keep it from overflowing.
  always_ff @(posedge i_clk) begin
    if (i_req_valid) begin
      q_write[wr_ptr] <= i_req_write;
      q_addr[wr_ptr]  <= i_req_addr;
      q_wdata[wr_ptr] <= i_req_wdata;
      q_op[wr_ptr]    <= i_req_op;
    end
  end

  always_ff @(posedge i_clk) begin
    if (!i_rst) begin
      wr_ptr       <= '0;
      rd_ptr       <= '0;
      count        <= '0;
      o_req_credit <= 1'b0;
    end else begin
      if (i_req_valid) begin
        wr_ptr <= (wr_ptr == PTR_W'(`LSU_REQ_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (o_iss_valid) begin
        rd_ptr <= (rd_ptr == PTR_W'(`LSU_REQ_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({i_req_valid, o_iss_valid})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      // one credit goes back in the cycle after each dequeue.
      o_req_credit <= o_iss_valid;
    end
  end

  assign head_addr = q_addr[rd_ptr];
  assign offset    = head_addr[2:0];
  assign is_nop    = (q_op[rd_ptr].raw == LSU_OP_NOP);

  always_comb begin
    case (q_op[rd_ptr].f.size)
      LSU_SIZE_BYTE: begin
        misaligned = 1'b0;
        base_mask  = 8'h01;
      end
      LSU_SIZE_HALF: begin
        misaligned = offset[0];
        base_mask  = 8'h03;
      end
      LSU_SIZE_WORD: begin
        misaligned = (offset[1:0] != 2'b00);
        base_mask  = 8'h0f;
      end
      default: begin
        misaligned = (offset != 3'b000);
        base_mask  = 8'hff;
      end
    endcase
  end

  // the head issues as soon as the aligner has room for its response.
  assign o_iss_valid  = (count != '0) && i_iss_room;
  assign o_iss_write  = q_write[rd_ptr];
  assign o_iss_op     = q_op[rd_ptr];
  assign o_iss_offset = offset;
  assign o_iss_err    = misaligned && !is_nop;
  assign o_iss_kill   = misaligned || is_nop;

  // killed entries still issue, but never touch the memory.
  assign o_mem_wr_en  = o_iss_valid && !o_iss_kill && o_iss_write;
  assign o_mem_rd_en  = o_iss_valid && !o_iss_kill && !o_iss_write;
  assign o_mem_index  = head_addr[`LSU_MEM_IDX_W+2:3];
  assign o_mem_wmask  = base_mask << offset;
  assign o_mem_wdata  = q_wdata[rd_ptr] << {offset, 3'b000};

endmodule

/* design/lsu_pkg.sv */
// lsu package: access size and memory-operation code types shared by the lsu blocks.
package lsu_pkg;

  // access size, held in bits [2:1] of the operation code.
  typedef enum logic [1:0] {
    LSU_SIZE_BYTE   = 2'd0,
    LSU_SIZE_HALF   = 2'd1,
    LSU_SIZE_WORD   = 2'd2,
    LSU_SIZE_DOUBLE = 2'd3
  } lsu_size_e;

  // field view of the code. bit 0 selects zero extension on loads.
  typedef struct packed {
    lsu_size_e size;
    logic      is_unsigned;
  } lsu_memop_f_t;

  // the code is read as a raw value to spot the no-op,
  // and as fields for everything else.
  // 000 lb, 001 lbu, 010 lh, 011 lhu, 100 lw, 101 lwu, 110 ld, 111 no-op.
  typedef union packed {
    logic [2:0]   raw;
    lsu_memop_f_t f;
  } lsu_memop_u;

  localparam logic [2:0] LSU_OP_NOP = 3'b111;

endpackage

/* design/lsu_settings.svh */
// lsu settings: sizing constants for the request queue, response path and data memory.
`ifndef LSU_SETTINGS_SVH
`define LSU_SETTINGS_SVH

// request queue entries, which is also the requester's credit count after reset.
`define LSU_REQ_DEPTH 4

// response queue entries, which bound the accesses issued and not yet sent.
`define LSU_RSP_QUEUE 4

// response credits held by the aligner after reset.
`define LSU_RSP_CREDITS 2

// width of the response credit counter.
`define LSU_RSP_CNT_W 16

// data memory size in 64-bit words, selected by address bits [10:3].
`define LSU_MEM_WORDS 256
`define LSU_MEM_IDX_W 8

`endif
